/* dispatchUnit.f */
+incdir+source
source/dispatchPkg.sv
source/instQueue.sv
source/regFile.sv
source/reorderBuffer.sv
source/renameDispatch.sv
source/dispatchUnit.sv
test/tbClock.sv
test/dispatchUnit_asserts.sv
test/dispatchUnit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the dispatch unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f dispatchUnit.f \
    --top-module dispatchUnit_tb -o simv > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation ended early"; exit 1; }
exit 0

/* source/dispatchPkg.sv */
`include "dispatch_config.svh"

package dispatchPkg;

    // Only ALU and LOAD write rd.
    typedef enum logic [1:0] {
        ALU    = 2'd0,
        LOAD   = 2'd1,
        STORE  = 2'd2,
        BRANCH = 2'd3
    } opClass_t;

    typedef logic [$clog2(`RegNum)-1:0] regName_t;
    typedef logic [`TagWidth-1:0]       robTag_t;
    typedef logic [`DataWidth-1:0]      word_t;

    // Decoded instruction from the issuer.
    typedef struct packed {
        opClass_t op;
        regName_t rd;
        regName_t rs1;
        regName_t rs2;
        word_t    imm;
        word_t    pc;
    } instPacket_t;

    // Source operand, either a value or a pending tag.
    typedef struct packed {
        logic    ready;
        robTag_t tag;
        word_t   value;
    } operand_t;

    typedef struct packed {
        instPacket_t inst;
        operand_t    src1;
        operand_t    src2;
        robTag_t     dest;
    } dispPacket_t;

    // One retired result.
    typedef struct packed {
        logic     writes;
        regName_t rd;
        robTag_t  tag;
        word_t    value;
    } commitInfo_t;

endpackage

/* source/dispatchUnit.sv */
`timescale 1ns/1ps

module dispatchUnit import dispatchPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        issueReq,
    input  instPacket_t issueInst,
    input  logic        dispAck,
    input  logic        wbValid,
    input  robTag_t     wbTag,
    input  word_t       wbValue,
    output logic        issueAck,
    output logic        dispReq,
    output dispPacket_t dispPacket,
    output logic        commitValid,
    output commitInfo_t commit
);
    logic        headValid;
    instPacket_t headInst;
    logic        pop;
    regName_t    rs1;
    regName_t    rs2;
    logic        rs1Busy;
    logic        rs2Busy;
    robTag_t     rs1Tag;
    robTag_t     rs2Tag;
    word_t       rs1Value;
    word_t       rs2Value;
    logic        renameEn;
    regName_t    renameReg;
    robTag_t     renameTag;
    logic        alloc;
    logic        allocWrites;
    regName_t    allocRd;
    robTag_t     allocTag;
    logic        robFull;
    robTag_t     lookTag1;
    robTag_t     lookTag2;
    logic        lookDone1;
    logic        lookDone2;
    word_t       lookValue1;
    word_t       lookValue2;

    instQueue queue0 (
        .clk, .rst, .flush, .issueReq, .issueInst, .pop,
        .issueAck, .headValid, .headInst
    );

    renameDispatch engine0 (
        .clk, .rst, .flush, .headValid, .headInst,
        .rs1Busy, .rs2Busy, .rs1Tag, .rs2Tag, .rs1Value, .rs2Value,
        .robFull, .allocTag, .lookDone1, .lookDone2, .lookValue1, .lookValue2,
        .dispAck, .pop, .rs1, .rs2, .renameEn, .renameReg, .renameTag,
        .alloc, .allocWrites, .allocRd, .lookTag1, .lookTag2,
        .dispReq, .dispPacket
    );

    regFile regs0 (
        .clk, .rst, .flush, .rs1, .rs2, .renameEn, .renameReg, .renameTag,
        .commitValid, .commit,
        .rs1Busy, .rs2Busy, .rs1Tag, .rs2Tag, .rs1Value, .rs2Value
    );

    reorderBuffer rob0 (
        .clk, .rst, .flush, .alloc, .allocWrites, .allocRd,
        .wbValid, .wbTag, .wbValue, .lookTag1, .lookTag2,
        .allocTag, .full(robFull), .lookDone1, .lookDone2,
        .lookValue1, .lookValue2, .commitValid, .commit
    );

endmodule

/* source/dispatch_config.svh */
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// Architectural register count, x0 included.
`define RegNum 32

// Width of one register value.
`define DataWidth 32

// Reorder buffer tag width and depth.
`define TagWidth 3
`define RobDepth 8

// Instruction queue entries.
`define QueueDepth 4

`endif

/* source/instQueue.sv */
`timescale 1ns/1ps
`include "dispatch_config.svh"

module instQueue import dispatchPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        issueReq,
    input  instPacket_t issueInst,
    input  logic        pop,
    output logic        issueAck,
    output logic        headValid,
    output instPacket_t headInst
);
    localparam int Depth    = `QueueDepth;
    localparam int PtrWidth = $clog2(Depth);

    instPacket_t         mem [Depth];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [PtrWidth:0]   count;
    logic                push;
    logic                doPop;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // One capture per request, then wait for issueReq to fall.
    assign push = issueReq && !issueAck && !flush && (count != (PtrWidth + 1)'(Depth));

    assign doPop     = pop && headValid;
    assign headValid = (count != '0);
    assign headInst  = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= issueInst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            issueAck <= 1'b0;
        end else begin
            if (push) begin
                issueAck <= 1'b1;
            end else if (issueAck && !issueReq) begin
                issueAck <= 1'b0;
            end

            if (flush) begin
                wrPtr <= '0;
                rdPtr <= '0;
                count <= '0;
            end else begin
                if (push) begin
                    wrPtr <= nextPtr(wrPtr);
                end
                if (doPop) begin
                    rdPtr <= nextPtr(rdPtr);
                end
                count <= count + (PtrWidth + 1)'(push) - (PtrWidth + 1)'(doPop);
            end
        end
    end

endmodule

/* source/regFile.sv */
`timescale 1ns/1ps
`include "dispatch_config.svh"

module regFile import dispatchPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  regName_t    rs1,
    input  regName_t    rs2,
    input  logic        renameEn,
    input  regName_t    renameReg,
    input  robTag_t     renameTag,
    input  logic        commitValid,
    input  commitInfo_t commit,
    output logic        rs1Busy,
    output logic        rs2Busy,
    output robTag_t     rs1Tag,
    output robTag_t     rs2Tag,
    output word_t       rs1Value,
    output word_t       rs2Value
);
    word_t              values [`RegNum];
    robTag_t            tags [`RegNum];
    logic [`RegNum-1:0] busy;
    logic               commitWrite;
    logic               rs1Hit;
    logic               rs2Hit;

    // x0 is never written and never renamed.
    assign commitWrite = commitValid && commit.writes && (commit.rd != '0);

    // Same-cycle commit is forwarded to the readers.
    assign rs1Hit = commitWrite && (commit.rd == rs1);
    assign rs2Hit = commitWrite && (commit.rd == rs2);

    assign rs1Value = rs1Hit ? commit.value : values[rs1];
    assign rs2Value = rs2Hit ? commit.value : values[rs2];
    assign rs1Tag   = tags[rs1];
    assign rs2Tag   = tags[rs2];
    assign rs1Busy  = busy[rs1] && !(rs1Hit && (tags[rs1] == commit.tag));
    assign rs2Busy  = busy[rs2] && !(rs2Hit && (tags[rs2] == commit.tag));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RegNum; i++) begin
                values[i] <= '0;
                tags[i]   <= '0;
            end
            busy <= '0;
        end else begin
            if (commitWrite) begin
                values[commit.rd] <= commit.value;
            end

            if (flush) begin
                busy <= '0;
            end else begin
                // Only the latest producer may release the register.
                if (commitWrite && (tags[commit.rd] == commit.tag)) begin
                    busy[commit.rd] <= 1'b0;
                end
                // A rename in the same cycle wins.
                if (renameEn && (renameReg != '0)) begin
                    busy[renameReg] <= 1'b1;
                    tags[renameReg] <= renameTag;
                end
            end
        end
    end

endmodule

/* source/renameDispatch.sv */
`timescale 1ns/1ps

module renameDispatch import dispatchPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        headValid,
    input  instPacket_t headInst,
    input  logic        rs1Busy,
    input  logic        rs2Busy,
    input  robTag_t     rs1Tag,
    input  robTag_t     rs2Tag,
    input  word_t       rs1Value,
    input  word_t       rs2Value,
    input  logic        robFull,
    input  robTag_t     allocTag,
    input  logic        lookDone1,
    input  logic        lookDone2,
    input  word_t       lookValue1,
    input  word_t       lookValue2,
    input  logic        dispAck,
    output logic        pop,
    output regName_t    rs1,
    output regName_t    rs2,
    output logic        renameEn,
    output regName_t    renameReg,
    output robTag_t     renameTag,
    output logic        alloc,
    output logic        allocWrites,
    output regName_t    allocRd,
    output robTag_t     lookTag1,
    output robTag_t     lookTag2,
    output logic        dispReq,
    output dispPacket_t dispPacket
);
    typedef enum logic [1:0] {
        stIdle,
        stRequest,
        stAckLow
    } state_t;

    state_t   state;
    logic     writesRd;
    operand_t src1;
    operand_t src2;

    // Register value, then finished ROB result, else wait on the tag.
    function automatic operand_t resolve(
        input regName_t r,
        input logic     busy,
        input robTag_t  tag,
        input word_t    regValue,
        input logic     robDone,
        input word_t    robValue
    );
        operand_t res;
        res = '0;
        if ((r == '0) || !busy) begin
            res.ready = 1'b1;
            res.value = regValue;
        end else if (robDone) begin
            res.ready = 1'b1;
            res.value = robValue;
        end else begin
            res.tag = tag;
        end
        return res;
    endfunction

    // Stores and branches never rename.
    assign writesRd = ((headInst.op == ALU) || (headInst.op == LOAD)) && (headInst.rd != '0);

    assign pop = (state == stIdle) && headValid && !robFull && !flush;

    assign rs1      = headInst.rs1;
    assign rs2      = headInst.rs2;
    assign lookTag1 = rs1Tag;
    assign lookTag2 = rs2Tag;

    assign alloc       = pop;
    assign allocWrites = writesRd;
    assign allocRd     = headInst.rd;
    assign renameEn    = pop && writesRd;
    assign renameReg   = headInst.rd;
    assign renameTag   = allocTag;

    assign src1 = resolve(headInst.rs1, rs1Busy, rs1Tag, rs1Value, lookDone1, lookValue1);
    assign src2 = resolve(headInst.rs2, rs2Busy, rs2Tag, rs2Value, lookDone2, lookValue2);

    assign dispReq = (state == stRequest);

    always_ff @(posedge clk) begin
        if (pop) begin
            dispPacket <= '{inst: headInst, src1: src1, src2: src2, dest: allocTag};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (pop) begin
                        state <= stRequest;
                    end
                end
                stRequest: begin
                    if (dispAck) begin
                        state <= stAckLow;
                    end
                end
                stAckLow: begin
                    // Four-phase return to zero.
                    if (!dispAck) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

/* source/reorderBuffer.sv */
`timescale 1ns/1ps
`include "dispatch_config.svh"

module reorderBuffer import dispatchPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        alloc,
    input  logic        allocWrites,
    input  regName_t    allocRd,
    input  logic        wbValid,
    input  robTag_t     wbTag,
    input  word_t       wbValue,
    input  robTag_t     lookTag1,
    input  robTag_t     lookTag2,
    output robTag_t     allocTag,
    output logic        full,
    output logic        lookDone1,
    output logic        lookDone2,
    output word_t       lookValue1,
    output word_t       lookValue2,
    output logic        commitValid,
    output commitInfo_t commit
);
    localparam int Depth = `RobDepth;

    logic [Depth-1:0]   valid;
    logic [Depth-1:0]   done;
    logic [Depth-1:0]   writesArr;
    regName_t           rdArr [Depth];
    word_t              valueArr [Depth];
    robTag_t            head;
    robTag_t            tail;
    logic [`TagWidth:0] count;
    logic               retire;
    logic               wbLive;
    logic               wbHit1;
    logic               wbHit2;

    function automatic robTag_t nextTag(input robTag_t tag);
        return (tag == robTag_t'(Depth - 1)) ? '0 : tag + 1'b1;
    endfunction

    assign allocTag = tail;
    assign full     = (count == (`TagWidth + 1)'(Depth));

    // Stale writebacks to freed entries are ignored.
    assign wbLive = wbValid && valid[wbTag];

    // In-order retirement of the head, one per cycle.
    assign retire      = valid[head] && done[head];
    assign commitValid = retire;
    assign commit      = '{
        writes: writesArr[head],
        rd:     rdArr[head],
        tag:    head,
        value:  valueArr[head]
    };

    // Lookups also see a writeback arriving this cycle.
    assign wbHit1     = wbLive && (wbTag == lookTag1);
    assign wbHit2     = wbLive && (wbTag == lookTag2);
    assign lookDone1  = valid[lookTag1] && (done[lookTag1] || wbHit1);
    assign lookDone2  = valid[lookTag2] && (done[lookTag2] || wbHit2);
    assign lookValue1 = wbHit1 ? wbValue : valueArr[lookTag1];
    assign lookValue2 = wbHit2 ? wbValue : valueArr[lookTag2];

    always_ff @(posedge clk) begin
        if (alloc) begin
            writesArr[tail] <= allocWrites;
            rdArr[tail]     <= allocRd;
        end
        if (wbLive) begin
            valueArr[wbTag] <= wbValue;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (wbLive) begin
                done[wbTag] <= 1'b1;
            end
            if (retire) begin
                valid[head] <= 1'b0;
                head        <= nextTag(head);
            end
            if (alloc) begin
                valid[tail] <= 1'b1;
                done[tail]  <= 1'b0;
                tail        <= nextTag(tail);
            end
            count <= count + (`TagWidth + 1)'(alloc) - (`TagWidth + 1)'(retire);
        end
    end

endmodule

/* test/dispatchUnit_asserts.sv */
`timescale 1ns/1ps

module dispatchUnit_asserts import dispatchPkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        flush,
    input logic        issueReq,
    input logic        issueAck,
    input logic        dispReq,
    input logic        dispAck,
    input dispPacket_t dispPacket,
    input logic        commitValid
);
    // A request only ends after its acknowledge, or on a flush.
    reqHeld: assert property (@(posedge clk) disable iff (rst)
        $fell(dispReq) |-> ($past(dispAck) || $past(flush)))
        else $error("dispReq dropped before dispAck");

    packetStable: assert property (@(posedge clk) disable iff (rst)
        (dispReq && $past(dispReq)) |-> $stable(dispPacket))
        else $error("dispPacket changed while dispReq was high");

    ackAfterReq: assert property (@(posedge clk) disable iff (rst)
        $rose(issueAck) |-> $past(issueReq))
        else $error("issueAck rose without issueReq");

    noCommitInReset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !commitValid)
        else $error("commitValid high during reset");

endmodule

bind dispatchUnit dispatchUnit_asserts asserts0 (.*);

/* test/dispatchUnit_tb.sv */
`timescale 1ns/1ps
`include "dispatch_config.svh"

module dispatchUnit_tb import dispatchPkg::*; ();
    typedef struct {
        robTag_t  tag;
        regName_t rd;
        logic     writes;
        logic     wbSent;
        int       wbEdge;
        word_t    value;
    } flight_t;

    logic        clk, rst, flush, issueReq, issueAck, dispAck, dispReq;
    logic        wbValid, commitValid;
    instPacket_t issueInst;
    robTag_t     wbTag;
    word_t       wbValue;
    dispPacket_t dispPacket;
    commitInfo_t commit;

    instPacket_t pendQ[$];
    flight_t     flight[$];
    // Results still returning for flushed tags.
    robTag_t     staleQ[$];
    word_t       arch [`RegNum];
    robTag_t     nextDest;
    int          cycle, errors, testsRun, testsFailed, issuedTotal, issueTarget, dispCount;
    int          ackWait, errBefore, base;
    logic        prevDispReq, ackEnable, wbEnable, flushReq;

    tbClock clock0 (.clk, .rst);

    dispatchUnit dut0 (
        .clk, .rst, .flush, .issueReq, .issueInst, .dispAck, .wbValid, .wbTag, .wbValue,
        .issueAck, .dispReq, .dispPacket, .commitValid, .commit
    );

    task automatic checkDispatch(input dispPacket_t actual, input dispPacket_t expected);
        if (actual !== expected) begin
            $display("FAIL time %0t dispPacket actual %h expected %h", $time, actual, expected);
            errors++;
        end
    endtask

    task automatic checkCommit(input commitInfo_t actual, input commitInfo_t expected);
        if (actual !== expected) begin
            $display("FAIL time %0t commit actual %h expected %h", $time, actual, expected);
            errors++;
        end
    endtask

    task automatic checkSignal(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAIL time %0t %s actual %b expected %b", $time, name, actual, expected);
            errors++;
        end
    endtask

    function automatic logic writesReg(input instPacket_t inst);
        return ((inst.op == ALU) || (inst.op == LOAD)) && (inst.rd != 0);
    endfunction

    // Latest earlier writer decides; a writeback counts once it landed by the pop edge.
    function automatic operand_t predictOperand(input regName_t r, input int popEdge);
        operand_t res;
        res = '0;
        res.ready = 1'b1;
        if (r == 0) begin
            return res;
        end
        res.value = arch[r];
        for (int i = flight.size() - 1; i >= 0; i--) begin
            if (flight[i].writes && (flight[i].rd == r)) begin
                if (flight[i].wbSent && (flight[i].wbEdge <= popEdge)) begin
                    res.value = flight[i].value;
                end else begin
                    res = '0;
                    res.tag = flight[i].tag;
                end
                return res;
            end
        end
        return res;
    endfunction

    task automatic endTest(input string name);
        testsRun++;
        if (errors != errBefore) begin
            testsFailed++;
        end
        $display("test %s: %s (%0d errors)", name, (errors == errBefore) ? "ok" : "FAIL",
                 errors - errBefore);
        errBefore = errors;
    endtask

    task automatic waitDrained();
        while (!((issuedTotal == issueTarget) && !issueReq && (pendQ.size() == 0)
                 && (flight.size() == 0))) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Monitor, model update, dispatch acknowledge and writebacks.
    always @(negedge clk) begin
        dispPacket_t exp;
        flight_t     ent;
        int          idx;
        if (!rst) begin
            if (dispReq && !prevDispReq) begin
                dispCount++;
                if (pendQ.size() == 0) begin
                    $display("dispatch appeared with no instruction issued at %0t", $time);
                    errors++;
                end else begin
                    exp.inst = pendQ.pop_front();
                    exp.src1 = predictOperand(exp.inst.rs1, cycle);
                    exp.src2 = predictOperand(exp.inst.rs2, cycle);
                    exp.dest = nextDest;
                    checkDispatch(dispPacket, exp);
                    ent = '{nextDest, exp.inst.rd, writesReg(exp.inst), 1'b0, 0, '0};
                    flight.push_back(ent);
                    nextDest++;
                end
            end
            prevDispReq = dispReq;
            if (commitValid) begin
                if (flight.size() == 0) begin
                    $display("commit appeared with nothing in flight at %0t", $time);
                    errors++;
                end else begin
                    ent = flight.pop_front();
                    if (!ent.wbSent) begin
                        $display("commit came before its writeback at %0t", $time);
                        errors++;
                    end
                    checkCommit(commit, '{ent.writes, ent.rd, ent.tag, ent.value});
                    if (ent.writes) begin
                        arch[ent.rd] = ent.value;
                    end
                end
            end
            wbValid = 1'b0;
            flush   = 1'b0;
            if (flushReq) begin
                flush    = 1'b1;
                flushReq = 1'b0;
                dispAck  = 1'b0;
                ackWait  = 0;
                pendQ.delete();
                foreach (flight[i]) begin
                    staleQ.push_back(flight[i].tag);
                end
                flight.delete();
                nextDest = '0;
            end else begin
                if (dispAck) begin
                    if (!dispReq) begin
                        dispAck = 1'b0;
                    end
                end else if (dispReq && ackEnable) begin
                    if (ackWait == 0) begin
                        dispAck = 1'b1;
                        ackWait = $urandom_range(0, 3);
                    end else begin
                        ackWait--;
                    end
                end
                if (staleQ.size() > 0) begin
                    wbValid = 1'b1;
                    wbTag   = staleQ.pop_front();
                    wbValue = $urandom;
                end else if (wbEnable && (flight.size() > 0) && ($urandom_range(0, 1) == 1)) begin
                    idx = $urandom_range(0, flight.size() - 1);
                    if (!flight[idx].wbSent) begin
                        flight[idx].wbSent = 1'b1;
                        flight[idx].wbEdge = cycle + 1;
                        flight[idx].value  = $urandom;
                        wbValid = 1'b1;
                        wbTag   = flight[idx].tag;
                        wbValue = flight[idx].value;
                    end
                end
            end
        end
    end

    // Issuer with the four-phase handshake.
    initial begin
        instPacket_t inst;
        word_t       pc;
        pc = 32'h1000;
        forever begin
            @(negedge clk);
            if (!rst && (issuedTotal < issueTarget)) begin
                inst.op  = opClass_t'($urandom_range(0, 3));
                inst.rd  = regName_t'($urandom_range(0, 7));
                inst.rs1 = regName_t'($urandom_range(0, 7));
                inst.rs2 = regName_t'($urandom_range(0, 7));
                inst.imm = $urandom;
                inst.pc  = pc;
                pc       = pc + 4;
                issueReq  = 1'b1;
                issueInst = inst;
                do @(negedge clk); while (!issueAck);
                pendQ.push_back(inst);
                issuedTotal++;
                issueReq = 1'b0;
                do @(negedge clk); while (issueAck);
            end
        end
    end

    initial begin
        while (cycle <= 200 * issueTarget + 1000) begin
            @(posedge clk);
        end
        $display("watchdog expired after %0d cycles", cycle);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h2eb1af45));
        {flush, issueReq, dispAck, wbValid, flushReq} = '0;
        {issueInst, wbTag, wbValue, nextDest} = '0;
        {errors, testsRun, testsFailed, issuedTotal, issueTarget} = '0;
        {dispCount, ackWait, errBefore, prevDispReq} = '0;
        ackEnable = 1'b1;
        wbEnable  = 1'b1;
        for (int i = 0; i < `RegNum; i++) begin
            arch[i] = '0;
        end
        while (rst !== 1'b0) @(negedge clk);
        repeat (3) begin
            @(negedge clk);
            checkSignal("issueAck", issueAck, 1'b0);
            checkSignal("dispReq", dispReq, 1'b0);
            checkSignal("commitValid", commitValid, 1'b0);
        end
        endTest("reset");

        issueTarget += 60;
        waitDrained();
        endTest("random traffic");

        // Back-pressure with acknowledges and writebacks held.
        ackEnable = 1'b0;
        wbEnable  = 1'b0;
        base      = dispCount;
        issueTarget += `RobDepth + `QueueDepth + 3;
        repeat (40) @(negedge clk);
        checkSignal("dispCountBounded", (dispCount - base) <= `RobDepth, 1'b1);
        ackEnable = 1'b1;
        repeat (80) @(negedge clk);
        checkSignal("dispCountFull", (dispCount - base) == `RobDepth, 1'b1);
        checkSignal("issueReq", issueReq, 1'b1);
        checkSignal("issueAck", issueAck, 1'b0);
        wbEnable = 1'b1;
        waitDrained();
        endTest("back-pressure");

        wbEnable = 1'b0;
        issueTarget += 6;
        while ((issuedTotal < issueTarget) || issueReq || issueAck) @(negedge clk);
        repeat (20) @(negedge clk);
        flushReq = 1'b1;
        while (flushReq || (staleQ.size() != 0)) @(negedge clk);
        wbEnable = 1'b1;
        issueTarget += 10;
        waitDrained();
        repeat (10) @(negedge clk);
        endTest("flush");

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* test/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 8 cycles, released on a falling edge.
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule
